//--- bench/tb_top.sv
`timescale 1ns/10ps

module tb_top;
   import tile_pkg::*;

   localparam int timeout_c = 50;

   logic        clk_i = 1'b0;
   logic        reset_i;
   logic        net_v_i;
   packet_s     net_data_i;
   logic        net_ready_o;
   logic        net_v_o;
   packet_s     net_data_o;
   logic        net_ready_i;
   dmem_req_s   core_req_i;
   logic        core_yumi_o;
   logic        core_rv_o;
   logic [31:0] core_rdata_o;
   logic        any_os_i;
   logic        freeze_o;

   logic [15:0] lfsr_r = 16'd79;
   logic [31:0] ref_mem [512];
   logic [8:0]  words [8];
   int          errors = 0;
   int          errors_at_start = 0;
   int          tests_run = 0;
   int          tests_failed = 0;

   tile_mem_top i_dut (.*);

   always #20 clk_i = ~clk_i;

   // taps of x^16 + x^14 + x^13 + x^11 + 1 in a right shift
   function logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
   endfunction

   function logic [31:0] take_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         val    = {val[30:0], lfsr_r[0]};
         lfsr_r = lfsr_next(lfsr_r);
      end
      return val;
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
                                               input logic [3:0] mask);
      logic [31:0] res;
      res = old;
      for (int b = 0; b < 4; b++)
      begin
         if (mask[b])
            res[8*b +: 8] = nw[8*b +: 8];
      end
      return res;
   endfunction

   function automatic packet_s make_packet(input logic [1:0] op, input logic [3:0] mask,
                                           input logic [22:0] addr, input logic [31:0] data,
                                           input logic [3:0] y, input logic [3:0] x);
      packet_s p;
      p.op   = op;
      p.mask = mask;
      p.addr = addr;
      p.data = data;
      p.y    = y;
      p.x    = x;
      return p;
   endfunction

   function automatic dmem_req_s make_local(input logic w, input logic [8:0] word,
                                            input logic [31:0] data, input logic [3:0] mask);
      dmem_req_s r;
      r               = '0;
      r.v             = 1'b1;
      r.w             = w;
      r.addr.loc.word = word;
      r.wdata         = data;
      r.mask          = mask;
      return r;
   endfunction

   function automatic dmem_req_s make_remote(input logic w, input logic [3:0] y,
                                             input logic [3:0] x, input logic [22:0] addr,
                                             input logic [31:0] data, input logic [3:0] mask);
      dmem_req_s r;
      r                 = '0;
      r.v               = 1'b1;
      r.w               = w;
      r.addr.rmt.remote = 1'b1;
      r.addr.rmt.y      = y;
      r.addr.rmt.x      = x;
      r.addr.rmt.addr   = addr;
      r.wdata           = data;
      r.mask            = mask;
      return r;
   endfunction

   task automatic expect_equal(input string test, input logic [95:0] exp,
                               input logic [95:0] act);
      assert (act === exp)
      else
      begin
         $display("Mismatch in %s: expected %h, actual %h", test, exp, act);
         errors++;
      end
   endtask

   task automatic expect_true(input string test, input logic cond, input string what);
      assert (cond === 1'b1)
      else
      begin
         $display("%s: %s", test, what);
         errors++;
      end
   endtask

   task automatic abort_on_timeout(input string what);
      $display("Timeout: %s", what);
      $display("CHECKS FAILED");
      $finish;
   endtask

   task automatic finish_test(input string test);
      tests_run++;
      if (errors == errors_at_start)
         $display("test %s: pass", test);
      else
      begin
         $display("test %s: fail, %0d errors", test, errors - errors_at_start);
         tests_failed++;
      end
      errors_at_start = errors;
   endtask

   // returns just after the clock edge that took the packet in
   task automatic push_packet(input packet_s pkt);
      int t;
      @(posedge clk_i);
      net_v_i    <= 1'b1;
      net_data_i <= pkt;
      t = 0;
      @(negedge clk_i);
      while (!net_ready_o && t < timeout_c)
      begin
         @(negedge clk_i);
         t++;
      end
      if (!net_ready_o)
         abort_on_timeout("net_ready_o stayed low");
      @(posedge clk_i);
      net_v_i <= 1'b0;
   endtask

   task automatic issue_req(input string test, input dmem_req_s req, output int waits);
      @(posedge clk_i);
      core_req_i <= req;
      waits = 0;
      @(negedge clk_i);
      while (!core_yumi_o && waits < timeout_c)
      begin
         @(negedge clk_i);
         waits++;
      end
      if (!core_yumi_o)
         abort_on_timeout({test, ", core_yumi_o never rose"});
      @(posedge clk_i);
      core_req_i.v <= 1'b0;
   endtask

   task automatic load_word(input string test, input logic [8:0] word, output logic [31:0] data);
      int waits;
      issue_req(test, make_local(1'b0, word, '0, 4'hf), waits);
      expect_true(test, waits == 0, "local load was not accepted in its first cycle");
      @(negedge clk_i);
      expect_true(test, core_rv_o, "no read valid one cycle after yumi");
      data = core_rdata_o;
   endtask

   initial
   begin
      logic [31:0] data;
      logic [31:0] got;
      logic [31:0] old;
      logic [3:0]  mask;
      logic [3:0]  y;
      logic [3:0]  x;
      logic [22:0] raddr;
      logic [22:0] magic [2];
      logic        os;
      packet_s     pkt;
      int          waits;
      int          polls;

      reset_i     = 1'b1;
      net_v_i     = 1'b0;
      net_data_i  = '0;
      net_ready_i = 1'b1;
      core_req_i  = '0;
      any_os_i    = 1'b0;
      repeat (10) @(posedge clk_i);
      reset_i <= 1'b0;

      @(negedge clk_i);
      expect_true("reset", freeze_o, "freeze_o is not set after reset");
      expect_true("reset", !core_rv_o, "core_rv_o is high after reset");
      expect_true("reset", net_ready_o, "net_ready_o is low after reset");
      finish_test("reset");

      // freeze_o changes on the second edge after intake
      for (int i = 0; i < 3; i++)
      begin
         pkt = make_packet((i == 1) ? 2'd2 : 2'd3, '0, '0, '0, '0, '0);
         push_packet(pkt);
         @(negedge clk_i);
         expect_equal("freeze", (i == 1) ? 1'b0 : 1'b1, freeze_o);
         @(negedge clk_i);
         expect_equal("freeze", (i == 1) ? 1'b1 : 1'b0, freeze_o);
      end
      finish_test("freeze");

      // alternate the low word bit so both banks see traffic
      for (int i = 0; i < 8; i++)
      begin
         words[i]    = take_bits(9);
         words[i][0] = i[0];
         data        = take_bits(32);
         issue_req("local_rw", make_local(1'b1, words[i], data, 4'hf), waits);
         expect_true("local_rw", waits == 0, "local store was not accepted in its first cycle");
         ref_mem[words[i]] = data;
      end
      for (int i = 0; i < 8; i++)
      begin
         load_word("local_rw", words[i], got);
         expect_equal("local_rw", ref_mem[words[i]], got);
      end
      finish_test("local_rw");

      // core reads the target word every cycle, blocking the network store
      mask = {1'b0, take_bits(3)} | 4'b0001;
      data = take_bits(32);
      pkt  = make_packet(2'd0, mask, {12'b0, words[0], 2'b00}, data, take_bits(4), take_bits(4));
      old  = ref_mem[words[0]];
      @(posedge clk_i);
      core_req_i <= make_local(1'b0, words[0], '0, '0);
      net_v_i    <= 1'b1;
      net_data_i <= pkt;
      for (int k = 0; k < 6; k++)
      begin
         @(negedge clk_i);
         if (k == 0)
            expect_true("remote_store", net_ready_o, "receive FIFO refused the store");
         expect_true("remote_store", core_yumi_o, "local read lost its bank to a store");
         if (k > 0)
            expect_equal("remote_store", old, core_rdata_o);
         @(posedge clk_i);
         net_v_i <= 1'b0;
         if (k == 5)
            core_req_i.v <= 1'b0;
      end
      @(negedge clk_i);
      expect_equal("remote_store", old, core_rdata_o);
      ref_mem[words[0]] = merge_bytes(old, data, mask);
      polls = 0;
      load_word("remote_store", words[0], got);
      while (got !== ref_mem[words[0]] && polls < timeout_c)
      begin
         load_word("remote_store", words[0], got);
         polls++;
      end
      expect_equal("remote_store", ref_mem[words[0]], got);
      finish_test("remote_store");

      y     = take_bits(4);
      x     = take_bits(4);
      raddr = take_bits(23);
      data  = take_bits(32);
      mask  = take_bits(4);
      pkt   = make_packet(2'd0, mask, raddr, data, y, x);
      @(posedge clk_i);
      net_ready_i <= 1'b0;
      core_req_i  <= make_remote(1'b1, y, x, raddr, data, mask);
      for (int k = 0; k < 4; k++)
      begin
         @(negedge clk_i);
         expect_true("outbound", net_v_o, "net_v_o is low for a remote store");
         expect_equal("outbound", pkt, net_data_o);
         expect_true("outbound", !core_yumi_o, "core_yumi_o rose while net_ready_i was low");
      end
      @(posedge clk_i);
      net_ready_i <= 1'b1;
      waits = 0;
      @(negedge clk_i);
      while (!core_yumi_o && waits < timeout_c)
      begin
         @(negedge clk_i);
         waits++;
      end
      if (!core_yumi_o)
         abort_on_timeout("outbound, core_yumi_o never rose after net_ready_i");
      expect_equal("outbound", pkt, net_data_o);
      @(posedge clk_i);
      core_req_i.v <= 1'b0;
      @(negedge clk_i);
      expect_true("outbound", !net_v_o, "net_v_o stayed high after the request left");
      finish_test("outbound");

      magic[0] = 23'h0bcde0;
      magic[1] = 23'h0a19ac;
      // the last pass repeats entry 1 with the os flag flipped
      for (int e = 0; e < 3; e++)
      begin
         os = (e == 2) ? !os : take_bits(1);
         @(posedge clk_i);
         any_os_i   <= os;
         core_req_i <= make_remote(1'b0, take_bits(4), take_bits(4), magic[(e == 0) ? 0 : 1],
                                   '0, 4'hf);
         @(negedge clk_i);
         expect_true("magic", core_yumi_o, "magic load was not accepted at once");
         expect_true("magic", !net_v_o, "magic load went out to the network");
         @(posedge clk_i);
         core_req_i.v <= 1'b0;
         @(negedge clk_i);
         expect_true("magic", core_rv_o, "no read valid one cycle after a magic load");
         expect_equal("magic", (e == 0) ? 32'h10203040 : {31'b0, os}, core_rdata_o);
      end
      finish_test("magic");

      $display("tests run: %0d, tests failed: %0d, failed checks: %0d",
               tests_run, tests_failed, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

//--- filelist.f
src/tile_pkg.sv
src/recv_fifo.sv
src/rx_dispatch.sv
src/dmem_router.sv
src/magic_load_hook.sv
src/bank_crossbar.sv
src/tile_mem_top.sv
bench/tb_top.sv

//--- src/bank_crossbar.sv
`timescale 1ns/10ps

module bank_crossbar
   (
      input  logic                clk_i,
      input  logic                reset_i,
      input  tile_pkg::mem_port_s local_port_i,
      input  tile_pkg::mem_port_s store_port_i,
      output logic                local_yumi_o,
      output logic                store_yumi_o,
      output logic                rv_o,
      output logic [31:0]         rdata_o
   );
   import tile_pkg::*;

   // words split into byte lanes for the write masks
   logic [mask_width_c-1:0][7:0] bank_mem [num_banks_c][bank_words_c];

   logic [$clog2(num_banks_c)-1:0]  local_bank;
   logic [$clog2(num_banks_c)-1:0]  store_bank;
   logic [$clog2(bank_words_c)-1:0] local_row;
   logic [$clog2(bank_words_c)-1:0] store_row;
   logic [$clog2(num_banks_c)-1:0]  rd_bank_r;
   logic [$clog2(bank_words_c)-1:0] rd_row_r;
   logic                            rv_r;

   // low word bit picks the bank and the rest picks the row
   assign local_bank = local_port_i.addr[0 +: $clog2(num_banks_c)];
   assign local_row  = local_port_i.addr[mem_addr_width_c-1:$clog2(num_banks_c)];
   assign store_bank = store_port_i.addr[0 +: $clog2(num_banks_c)];
   assign store_row  = store_port_i.addr[mem_addr_width_c-1:$clog2(num_banks_c)];

   // local port has fixed priority and always wins its bank
   assign local_yumi_o = local_port_i.v;
   assign store_yumi_o = store_port_i.v & (~local_port_i.v | (local_bank != store_bank));

   always_ff @(posedge clk_i)
   begin
      for (int b = 0; b < mask_width_c; b++)
      begin
         if (local_yumi_o && local_port_i.w && local_port_i.mask[b])
            bank_mem[local_bank][local_row][b] <= local_port_i.data[8*b +: 8];
         if (store_yumi_o && store_port_i.w && store_port_i.mask[b])
            bank_mem[store_bank][store_row][b] <= store_port_i.data[8*b +: 8];
      end
   end

   // read address held for the return cycle
   always_ff @(posedge clk_i)
   begin
      if (local_yumi_o && !local_port_i.w)
      begin
         rd_bank_r <= local_bank;
         rd_row_r  <= local_row;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         rv_r <= 1'b0;
      else
         rv_r <= local_yumi_o & ~local_port_i.w;
   end

   assign rv_o    = rv_r;
   assign rdata_o = bank_mem[rd_bank_r][rd_row_r];

endmodule

//--- src/dmem_router.sv
`timescale 1ns/10ps

module dmem_router
   (
      input  tile_pkg::dmem_req_s core_req_i,
      output logic                core_yumi_o,
      input  logic                magic_v_i,
      output tile_pkg::mem_port_s local_port_o,
      input  logic                local_yumi_i,
      output logic                net_v_o,
      output tile_pkg::packet_s   net_data_o,
      input  logic                net_ready_i
   );
   import tile_pkg::*;

   logic is_remote;
   logic remote_read;

   // top address bit decides between the banks and the network
   assign is_remote   = core_req_i.addr.rmt.remote;
   assign remote_read = core_req_i.v & is_remote & ~core_req_i.w;

   // local path
   assign local_port_o.v    = core_req_i.v & ~is_remote;
   assign local_port_o.w    = core_req_i.w;
   assign local_port_o.addr = core_req_i.addr.loc.word;
   assign local_port_o.data = core_req_i.wdata;
   assign local_port_o.mask = core_req_i.mask;

   // outbound path, only remote writes leave the tile
   assign net_v_o = core_req_i.v & is_remote & core_req_i.w & ~magic_v_i;

   always_comb
   begin
      net_data_o.op   = op_remote_store_c;
      net_data_o.mask = core_req_i.mask;
      net_data_o.addr = core_req_i.addr.rmt.addr;
      net_data_o.data = core_req_i.wdata;
      net_data_o.y    = core_req_i.addr.rmt.y;
      net_data_o.x    = core_req_i.addr.rmt.x;
   end

   // any of the three consumers may take the request
   assign core_yumi_o = local_yumi_i | magic_v_i | (net_v_o & net_ready_i);

   // remote loads are served only through the magic hook,
   // anything else would hang the core waiting for yumi
   always_comb
   begin
      a_remote_read_is_magic: assert #0 (!remote_read || magic_v_i);
   end

endmodule

//--- src/magic_load_hook.sv
`timescale 1ns/10ps

module magic_load_hook
   (
      input  logic                 clk_i,
      input  logic                 reset_i,
      input  tile_pkg::dmem_req_s  core_req_i,
      input  logic                 any_os_i,
      output logic                 magic_v_o,
      input  logic                 mem_rv_i,
      input  logic [31:0]          mem_rdata_i,
      output logic                 core_rv_o,
      output logic [31:0]          core_rdata_o
   );
   import tile_pkg::*;

   logic [magic_num_c-1:0]                   hit;
   logic [magic_num_c-1:0]                   hit_r;
   logic [magic_num_c-1:0][data_width_c-1:0] magic_data;

   // entry 1 reports the os flag in bit 0
   assign magic_data = {{{(data_width_c-1){1'b0}}, any_os_i}, magic_const_c};

   always_comb
   begin
      for (int i = 0; i < magic_num_c; i++)
      begin
         hit[i] = core_req_i.v & ~core_req_i.w & core_req_i.addr.rmt.remote
                & (core_req_i.addr.rmt.addr == magic_addr_c[i]);
      end
   end

   assign magic_v_o = |hit;

   // one cycle delay to line up with a bank read
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         hit_r <= '0;
      else
         hit_r <= hit;
   end

   always_comb
   begin
      core_rv_o    = mem_rv_i | (|hit_r);
      core_rdata_o = mem_rdata_i;
      for (int i = 0; i < magic_num_c; i++)
      begin
         if (hit_r[i])
            core_rdata_o = magic_data[i];
      end
   end

   // the magic slot must not overwrite a real bank return
   a_no_return_clash: assert property (@(posedge clk_i) disable iff (reset_i)
      !((|hit_r) && mem_rv_i));

endmodule

//--- src/recv_fifo.sv
`timescale 1ns/10ps

module recv_fifo
   (
      input  logic             clk_i,
      input  logic             reset_i,
      input  logic             v_i,
      input  tile_pkg::packet_s data_i,
      output logic             ready_o,
      output logic             v_o,
      output tile_pkg::packet_s data_o,
      input  logic             yumi_i
   );
   import tile_pkg::*;

   packet_s                         mem_r [fifo_els_c];
   logic [$clog2(fifo_els_c)-1:0]   wr_ptr_r;
   logic [$clog2(fifo_els_c)-1:0]   rd_ptr_r;
   logic [$clog2(fifo_els_c+1)-1:0] count_r;
   logic                            push;

   // a pop in the same cycle frees a slot even when full
   assign ready_o = (count_r != fifo_els_c) | yumi_i;
   assign push    = v_i & ready_o;
   assign v_o     = (count_r != '0);
   assign data_o  = mem_r[rd_ptr_r];

   always_ff @(posedge clk_i)
   begin
      if (push)
         mem_r[wr_ptr_r] <= data_i;
   end

   // depth is a power of two, so the pointers wrap on their own
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_r <= wr_ptr_r + 1'b1;
         if (yumi_i)
            rd_ptr_r <= rd_ptr_r + 1'b1;
         case ({push, yumi_i})
            2'b10:   count_r <= count_r + 1'b1;
            2'b01:   count_r <= count_r - 1'b1;
            default: count_r <= count_r;
         endcase
      end
   end

   // the dispatcher only pops a packet that is present
   a_yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
      yumi_i |-> v_o);

endmodule

//--- src/rx_dispatch.sv
`timescale 1ns/10ps

module rx_dispatch
   (
      input  logic                clk_i,
      input  logic                reset_i,
      input  logic                head_v_i,
      input  tile_pkg::packet_s   head_i,
      output logic                head_yumi_o,
      output tile_pkg::mem_port_s store_port_o,
      input  logic                store_yumi_i,
      output logic                freeze_o
   );
   import tile_pkg::*;

   logic is_store;
   logic is_freeze;
   logic is_unfreeze;
   logic is_unknown;

   assign is_store    = head_v_i & (head_i.op == op_remote_store_c);
   assign is_freeze   = head_v_i & (head_i.op == op_freeze_c);
   assign is_unfreeze = head_v_i & (head_i.op == op_unfreeze_c);
   assign is_unknown  = head_v_i & ~(is_store | is_freeze | is_unfreeze);

   // remote store goes to the network port of the crossbar, word aligned
   assign store_port_o.v    = is_store;
   assign store_port_o.w    = 1'b1;
   assign store_port_o.addr = head_i.addr[$clog2(mask_width_c) +: mem_addr_width_c];
   assign store_port_o.data = head_i.data;
   assign store_port_o.mask = head_i.mask;

   // control packets and unknown ops drain at once, stores wait for the bank
   assign head_yumi_o = is_freeze | is_unfreeze | is_unknown | (is_store & store_yumi_i);

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         freeze_o <= 1'b1;
      else if (is_freeze)
         freeze_o <= 1'b1;
      else if (is_unfreeze)
         freeze_o <= 1'b0;
   end

   // the network never sends op 1 to this tile
   a_no_unknown_op: assert property (@(posedge clk_i) disable iff (reset_i)
      !is_unknown);

endmodule

//--- src/tile_mem_top.sv
`timescale 1ns/10ps

module tile_mem_top
   (
      input  logic                clk_i,
      input  logic                reset_i,

      // packets from the network
      input  logic                net_v_i,
      input  tile_pkg::packet_s   net_data_i,
      output logic                net_ready_o,

      // outbound remote stores
      output logic                net_v_o,
      output tile_pkg::packet_s   net_data_o,
      input  logic                net_ready_i,

      // core data port
      input  tile_pkg::dmem_req_s core_req_i,
      output logic                core_yumi_o,
      output logic                core_rv_o,
      output logic [31:0]         core_rdata_o,

      input  logic                any_os_i,
      output logic                freeze_o
   );
   import tile_pkg::*;

   logic                    head_v;
   packet_s                 head;
   logic                    head_yumi;
   mem_port_s               store_port;
   logic                    store_yumi;
   mem_port_s               local_port;
   logic                    local_yumi;
   logic                    magic_v;
   logic                    mem_rv;
   logic [data_width_c-1:0] mem_rdata;

   recv_fifo i_recv_fifo (
      .clk_i, .reset_i,
      .v_i(net_v_i), .data_i(net_data_i), .ready_o(net_ready_o),
      .v_o(head_v), .data_o(head), .yumi_i(head_yumi)
   );

   rx_dispatch i_rx_dispatch (
      .clk_i, .reset_i,
      .head_v_i(head_v), .head_i(head), .head_yumi_o(head_yumi),
      .store_port_o(store_port), .store_yumi_i(store_yumi),
      .freeze_o
   );

   dmem_router i_dmem_router (
      .core_req_i, .core_yumi_o, .magic_v_i(magic_v),
      .local_port_o(local_port), .local_yumi_i(local_yumi),
      .net_v_o, .net_data_o, .net_ready_i
   );

   magic_load_hook i_magic_load_hook (
      .clk_i, .reset_i, .core_req_i, .any_os_i,
      .magic_v_o(magic_v), .mem_rv_i(mem_rv), .mem_rdata_i(mem_rdata),
      .core_rv_o, .core_rdata_o
   );

   bank_crossbar i_bank_crossbar (
      .clk_i, .reset_i,
      .local_port_i(local_port), .store_port_i(store_port),
      .local_yumi_o(local_yumi), .store_yumi_o(store_yumi),
      .rv_o(mem_rv), .rdata_o(mem_rdata)
   );

endmodule

//--- src/tile_pkg.sv
package tile_pkg;

   // datapath widths
   localparam int data_width_c = 32;
   localparam int addr_width_c = 32;
   localparam int x_width_c    = 4;
   localparam int y_width_c    = 4;
   localparam int mask_width_c = data_width_c / 8;

   // in-tile byte address carried by a packet
   localparam int remote_addr_width_c = addr_width_c - x_width_c - y_width_c - 1;

   // banked memory geometry
   localparam int num_banks_c      = 2;
   localparam int bank_words_c     = 256;
   localparam int mem_addr_width_c = $clog2(num_banks_c) + $clog2(bank_words_c);

   // receive buffer depth
   localparam int fifo_els_c = 4;

   // packet ops, value 1 is unused
   localparam logic [1:0] op_remote_store_c = 2'd0;
   localparam logic [1:0] op_freeze_c       = 2'd2;
   localparam logic [1:0] op_unfreeze_c     = 2'd3;

   // magic load addresses, entry 0 in the low slice
   localparam int magic_num_c = 2;
   localparam logic [magic_num_c-1:0][remote_addr_width_c-1:0] magic_addr_c =
      {23'h0A19AC, 23'h0BCDE0};
   localparam logic [data_width_c-1:0] magic_const_c = 32'h10203040;

   typedef struct packed {
      logic [1:0]                     op;
      logic [mask_width_c-1:0]        mask;
      logic [remote_addr_width_c-1:0] addr;
      logic [data_width_c-1:0]        data;
      logic [y_width_c-1:0]           y;
      logic [x_width_c-1:0]           x;
   } packet_s;

   // core address seen either as a network target or as a local word
   typedef union packed {
      struct packed {
         logic                           remote;
         logic [y_width_c-1:0]           y;
         logic [x_width_c-1:0]           x;
         logic [remote_addr_width_c-1:0] addr;
      } rmt;
      struct packed {
         logic [addr_width_c-mem_addr_width_c-$clog2(mask_width_c)-1:0] unused;
         logic [mem_addr_width_c-1:0]                                 word;
         logic [$clog2(mask_width_c)-1:0]                             byte_off;
      } loc;
   } addr_u;

   typedef struct packed {
      logic                    v;
      logic                    w;
      addr_u                   addr;
      logic [data_width_c-1:0] wdata;
      logic [mask_width_c-1:0] mask;
   } dmem_req_s;

   typedef struct packed {
      logic                        v;
      logic                        w;
      logic [mem_addr_width_c-1:0] addr;
      logic [data_width_c-1:0]     data;
      logic [mask_width_c-1:0]     mask;
   } mem_port_s;

endpackage
